// ==== speed_macros.svh ====
`ifndef SPEED_MACROS_SVH
`define SPEED_MACROS_SVH

// datapath widths
`define SAMPLE_W 16
`define FACTOR_W 4
`define STEP_W 4

// control widths
`define SPEED_W 4
`define PHASE_W 4 // phase tops out at 11

// speed code values
`define CODE_NORMAL 4'b0000
`define CODE_MUTE 4'b1000

// fast band 1001..1111 gives N = code - 7
`define FAST_BIAS 4'd7

// slow band 0001..0111 gives N = code + 1
`define SLOW_BIAS 4'd1

`endif

// ==== audio_pkg.sv ====
`default_nettype none

`include "speed_macros.svh"

package audio_pkg;

	// one signed pcm word
	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// speed ratio N, 1 to 8
	typedef logic [`FACTOR_W-1:0] factor_t;

	// blend index j between the two stores
	typedef logic [`STEP_W-1:0] blend_step_t;

endpackage

`default_nettype wire

// ==== speed_pkg.sv ====
`default_nettype none

`include "speed_macros.svh"

package speed_pkg;

	// raw code from the player front end
	typedef logic [`SPEED_W-1:0] speed_code_t;

	// position inside one output cycle
	typedef logic [`PHASE_W-1:0] phase_t;

	// decoded behaviour of the unit
	typedef enum logic [2:0] {
		MODE_NORMAL,
		MODE_FAST,
		MODE_SLOW_REPEAT,
		MODE_SLOW_INTERP,
		MODE_MUTE
	} play_mode_e;

	// what the output register takes on a step
	typedef enum logic [2:0] {
		SEL_HOLD,   // keep data_out
		SEL_INPUT,  // fresh sample
		SEL_STORE1, // older stored sample
		SEL_STORE2, // newer stored sample
		SEL_BLEND,  // weighted mix
		SEL_ZERO    // mute
	} out_sel_e;

endpackage

`default_nettype wire

// ==== playback_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "speed_macros.svh"

module playback_ctrl (
	input wire i_clk,
	input wire i_rst,
	input wire speed_pkg::speed_code_t play_speed,
	input wire slot_way,
	input wire i2s_request,
	input wire data_valid,

	output logic request_data,
	output logic valid,
	output speed_pkg::out_sel_e out_sel,
	output logic load_store1,
	output logic shift_store,
	output logic load_store2,
	output audio_pkg::blend_step_t blend_step,
	output audio_pkg::factor_t factor
);

	import speed_pkg::*;
	import audio_pkg::*;

	localparam phase_t PH_FIRST = phase_t'(1);
	localparam phase_t PH_LOAD2 = phase_t'(2);
	localparam phase_t PH_SHOW1 = phase_t'(3); // first interp output phase

	play_mode_e mode;
	phase_t phase, phase_next;
	logic step;
	logic request_next, valid_next;

	assign step = i2s_request & data_valid;

	// speed code to mode and ratio
	always_comb begin
		if (play_speed == `CODE_NORMAL) begin
			mode = MODE_NORMAL;
			factor = factor_t'(1);
		end else if (play_speed == `CODE_MUTE) begin
			mode = MODE_MUTE;
			factor = factor_t'(1);
		end else if (play_speed[`SPEED_W-1]) begin
			mode = MODE_FAST;
			factor = factor_t'(play_speed - `FAST_BIAS);
		end else begin
			mode = slot_way ? MODE_SLOW_INTERP : MODE_SLOW_REPEAT;
			factor = factor_t'(play_speed + `SLOW_BIAS);
		end
	end

	always_comb begin
		request_next = request_data;
		valid_next = valid;
		phase_next = phase;
		out_sel = SEL_HOLD;
		load_store1 = 1'b0;
		shift_store = 1'b0;
		load_store2 = 1'b0;
		blend_step = '0;
		if (step) begin
			case (mode)
				MODE_NORMAL: begin
					out_sel = SEL_INPUT;
					valid_next = 1'b1;
					request_next = 1'b1;
					phase_next = PH_FIRST;
				end
				MODE_FAST: begin
					request_next = 1'b1;
					if (phase == phase_t'(factor)) begin
						out_sel = SEL_INPUT; // keep one in N
						valid_next = 1'b1;
						phase_next = PH_FIRST;
					end else begin
						valid_next = 1'b0; // dropped sample
						phase_next = phase + phase_t'(1);
					end
				end
				MODE_SLOW_REPEAT: begin
					valid_next = 1'b1;
					if (phase == phase_t'(factor)) begin
						out_sel = SEL_INPUT;
						load_store1 = 1'b1;
						request_next = 1'b1;
						phase_next = PH_FIRST;
					end else begin
						out_sel = SEL_STORE1; // repeat last capture
						request_next = 1'b0;
						phase_next = phase + phase_t'(1);
					end
				end
				MODE_SLOW_INTERP: begin
					if (phase == PH_FIRST) begin
						shift_store = 1'b1; // newer becomes older
						valid_next = 1'b0;
						request_next = 1'b1;
						phase_next = phase + phase_t'(1);
					end else if (phase == PH_LOAD2) begin
						load_store2 = 1'b1;
						valid_next = 1'b0;
						request_next = 1'b1;
						phase_next = phase + phase_t'(1);
					end else if (phase == phase_t'(factor) + PH_SHOW1) begin
						out_sel = SEL_STORE2;
						valid_next = 1'b1;
						request_next = 1'b0;
						phase_next = PH_FIRST;
					end else begin
						out_sel = (phase == PH_SHOW1) ? SEL_STORE1 : SEL_BLEND;
						blend_step = blend_step_t'(phase - PH_SHOW1);
						valid_next = 1'b1;
						request_next = 1'b0;
						phase_next = phase + phase_t'(1);
					end
				end
				default: begin
					out_sel = SEL_ZERO; // phase holds in mute
					valid_next = 1'b0;
					request_next = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			phase <= PH_FIRST;
			request_data <= 1'b0;
			valid <= 1'b0;
		end else begin
			phase <= phase_next;
			request_data <= request_next;
			valid <= valid_next;
		end
	end

	// phase stays inside the cycle of the decoded ratio
	a_phase_range: assert property (@(posedge i_clk) disable iff (i_rst)
		step |-> (phase >= PH_FIRST) && (phase <= phase_t'(factor) + PH_SHOW1))
		else $error("phase %0d out of range for N %0d", phase, factor);

	// stores only move on a step
	a_store_on_step: assert property (@(posedge i_clk) disable iff (i_rst)
		(load_store1 || shift_store || load_store2) |-> step)
		else $error("store control without step");

endmodule

`default_nettype wire

// ==== sample_datapath.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "speed_macros.svh"

module sample_datapath (
	input wire i_clk,
	input wire i_rst,
	input wire audio_pkg::sample_t data_in,
	input wire speed_pkg::out_sel_e out_sel,
	input wire load_store1,
	input wire shift_store,
	input wire load_store2,
	input wire audio_pkg::blend_step_t blend_step,
	input wire audio_pkg::factor_t factor,

	output audio_pkg::sample_t data_out
);

	import audio_pkg::*;
	import speed_pkg::*;

	typedef logic signed [`SAMPLE_W+`FACTOR_W:0] product_t; // sample times weight

	sample_t store_1, store_2;
	sample_t blend;
	sample_t out_next;

	// weights carry a zero sign bit so the divide stays signed
	logic signed [`FACTOR_W+1:0] weight_1, weight_2, divisor;
	product_t term_1, term_2;

	assign weight_1 = $signed({2'b00, factor - blend_step});
	assign weight_2 = $signed({2'b00, blend_step});
	assign divisor = $signed({2'b00, factor});

	// each term truncates toward zero on its own
	assign term_1 = (product_t'(store_1) * product_t'(weight_1)) / product_t'(divisor);
	assign term_2 = (product_t'(store_2) * product_t'(weight_2)) / product_t'(divisor);
	assign blend = sample_t'(term_1 + term_2);

	always_comb begin
		case (out_sel)
			SEL_INPUT: out_next = data_in;
			SEL_STORE1: out_next = store_1;
			SEL_STORE2: out_next = store_2;
			SEL_BLEND: out_next = blend;
			SEL_ZERO: out_next = '0;
			default: out_next = data_out; // hold
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			store_1 <= '0;
			store_2 <= '0;
		end else begin
			if (shift_store) begin
				store_1 <= store_2;
			end else if (load_store1) begin
				store_1 <= data_in;
			end
			if (load_store2) begin
				store_2 <= data_in;
			end
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			data_out <= '0;
		end else begin
			data_out <= out_next;
		end
	end

	// store_1 has one source per step
	a_store1_single: assert property (@(posedge i_clk) disable iff (i_rst)
		!(shift_store && load_store1))
		else $error("shift_store and load_store1 together");

endmodule

`default_nettype wire

// ==== speed_player.sv ====
`default_nettype none
`timescale 1ns/100ps

module speed_player (
	input wire i_clk,
	input wire i_rst,
	input wire speed_pkg::speed_code_t play_speed,
	input wire slot_way, // 1 interpolate, 0 repeat
	input wire i2s_request,
	input wire audio_pkg::sample_t data_in,
	input wire data_valid,

	output logic request_data,
	output audio_pkg::sample_t data_out,
	output logic valid
);

	speed_pkg::out_sel_e out_sel;
	logic load_store1;
	logic shift_store;
	logic load_store2;
	audio_pkg::blend_step_t blend_step;
	audio_pkg::factor_t factor;

	playback_ctrl ctrl_i (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.play_speed (play_speed),
		.slot_way (slot_way),
		.i2s_request (i2s_request),
		.data_valid (data_valid),
		.request_data (request_data),
		.valid (valid),
		.out_sel (out_sel),
		.load_store1 (load_store1),
		.shift_store (shift_store),
		.load_store2 (load_store2),
		.blend_step (blend_step),
		.factor (factor)
	);

	sample_datapath datapath_i (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.data_in (data_in),
		.out_sel (out_sel),
		.load_store1 (load_store1),
		.shift_store (shift_store),
		.load_store2 (load_store2),
		.blend_step (blend_step),
		.factor (factor),
		.data_out (data_out)
	);

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 8
) (
	input wire reset_req,
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset from time zero, then again on each request
	initial begin
		rst <= 1'b1;
		forever begin
			repeat (RESET_CYCLES) @(posedge clk);
			rst <= 1'b0;
			do begin
				@(posedge clk);
			end while (!reset_req);
			rst <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== speed_player_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "speed_macros.svh"

module speed_player_tb;

	import audio_pkg::*;
	import speed_pkg::*;

	localparam int NUM_SEGS = 23; // normal, 3 x 7 ratios, mute
	localparam int SEG_LEN = 400;
	localparam int RESET_LEN = 8;
	localparam int TIMEOUT_CYCLES = NUM_SEGS * (SEG_LEN + RESET_LEN + 12) + 100;

	logic clk, rst;
	logic reset_req;
	speed_code_t play_speed;
	logic slot_way;
	logic i2s_request;
	sample_t data_in;
	logic data_valid;
	logic request_data;
	sample_t data_out;
	logic valid;

	// reference model state
	int m_phase;
	sample_t m_store1, m_store2, m_out;
	logic m_valid, m_req;

	integer seed = 32'hfbe6;
	int cycle_count = 0;
	int n;

	tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(RESET_LEN)) clock_i (
		.reset_req (reset_req),
		.clk (clk),
		.rst (rst)
	);

	speed_player dut_i (
		.i_clk (clk),
		.i_rst (rst),
		.play_speed (play_speed),
		.slot_way (slot_way),
		.i2s_request (i2s_request),
		.data_in (data_in),
		.data_valid (data_valid),
		.request_data (request_data),
		.data_out (data_out),
		.valid (valid)
	);

	function automatic play_mode_e decode_mode(input speed_code_t code, input logic way);
		if (code == `CODE_NORMAL) return MODE_NORMAL;
		if (code == `CODE_MUTE) return MODE_MUTE;
		if (code[`SPEED_W-1]) return MODE_FAST;
		return way ? MODE_SLOW_INTERP : MODE_SLOW_REPEAT;
	endfunction

	function automatic int decode_ratio(input speed_code_t code);
		if (code == `CODE_NORMAL || code == `CODE_MUTE) return 1;
		if (code[`SPEED_W-1]) return int'(code) - 7; // 2x .. 8x
		return int'(code) + 1; // 1/2x .. 1/8x
	endfunction

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic model_reset();
		m_phase = 1;
		m_store1 = '0;
		m_store2 = '0;
		m_out = '0;
		m_valid = 1'b0;
		m_req = 1'b0;
	endtask

	// one clock of the model on the inputs the DUT just sampled
	task automatic model_step();
		play_mode_e mode;
		int ratio;
		int j;
		int term_old, term_new;
		mode = decode_mode(play_speed, slot_way);
		ratio = decode_ratio(play_speed);
		if (i2s_request && data_valid) begin
			case (mode)
				MODE_NORMAL: begin
					m_out = data_in;
					m_valid = 1'b1;
					m_req = 1'b1;
					m_phase = 1;
				end
				MODE_FAST: begin
					m_req = 1'b1;
					m_valid = (m_phase == ratio);
					if (m_phase == ratio) m_out = data_in;
					m_phase = (m_phase == ratio) ? 1 : m_phase + 1;
				end
				MODE_SLOW_REPEAT: begin
					m_valid = 1'b1;
					m_req = (m_phase == ratio);
					if (m_phase == ratio) begin
						m_out = data_in;
						m_store1 = data_in;
					end else begin
						m_out = m_store1;
					end
					m_phase = (m_phase == ratio) ? 1 : m_phase + 1;
				end
				MODE_SLOW_INTERP: begin
					if (m_phase <= 2) begin
						if (m_phase == 1) m_store1 = m_store2;
						else m_store2 = data_in;
						m_valid = 1'b0;
						m_req = 1'b1;
						m_phase = m_phase + 1;
					end else begin
						m_valid = 1'b1;
						m_req = 1'b0;
						if (m_phase == 3) begin
							m_out = m_store1;
						end else if (m_phase == ratio + 3) begin
							m_out = m_store2;
						end else begin
							j = m_phase - 3;
							term_old = (int'(m_store1) * (ratio - j)) / ratio;
							term_new = (int'(m_store2) * j) / ratio;
							m_out = sample_t'(term_old + term_new);
						end
						m_phase = (m_phase == ratio + 3) ? 1 : m_phase + 1;
					end
				end
				default: begin
					m_out = '0; // mute holds the phase
					m_valid = 1'b0;
					m_req = 1'b0;
				end
			endcase
		end
	endtask

	task automatic drive_random(input logic extremes);
		int pick;
		i2s_request <= (($random(seed) & 3) != 0); // about 75% high
		data_valid <= (($random(seed) & 3) != 0);
		pick = $random(seed) & 7;
		if (extremes && pick == 0) data_in <= 16'h8000;
		else if (extremes && pick == 1) data_in <= 16'h7fff;
		else data_in <= sample_t'($random(seed));
	endtask

	task automatic check_outputs();
		assert (data_out === m_out) else begin
			$display("MISMATCH data_out: got %h, expected %h", data_out, m_out);
			stop_run();
		end
		assert (valid === m_valid) else begin
			$display("MISMATCH valid: got %h, expected %h", valid, m_valid);
			stop_run();
		end
		assert (request_data === m_req) else begin
			$display("MISMATCH request_data: got %h, expected %h", request_data, m_req);
			stop_run();
		end
	endtask

	task automatic run_segment(input speed_code_t code, input logic way, input logic extremes);
		@(posedge clk);
		play_speed <= code;
		slot_way <= way;
		i2s_request <= 1'b0;
		data_valid <= 1'b0;
		reset_req <= 1'b1;
		@(posedge clk);
		reset_req <= 1'b0;
		@(negedge clk);
		model_reset();
		while (rst) begin
			check_outputs();
			@(negedge clk);
		end
		check_outputs(); // out of reset before any step
		repeat (SEG_LEN) begin
			@(posedge clk);
			model_step();
			drive_random(extremes);
			@(negedge clk);
			check_outputs();
		end
	endtask

	initial begin
		play_speed <= `CODE_NORMAL;
		slot_way <= 1'b0;
		i2s_request <= 1'b0;
		data_in <= '0;
		data_valid <= 1'b0;
		reset_req <= 1'b0;
		model_reset();
		run_segment(`CODE_NORMAL, 1'b0, 1'b0);
		for (n = 2; n <= 8; n++) run_segment(speed_code_t'(n + 7), 1'b0, 1'b0);
		for (n = 2; n <= 8; n++) run_segment(speed_code_t'(n - 1), 1'b0, 1'b0);
		for (n = 2; n <= 8; n++) run_segment(speed_code_t'(n - 1), 1'b1, (n % 2) == 0);
		run_segment(`CODE_MUTE, 1'b1, 1'b0);
		$display("TEST OK");
		$finish;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
audio_pkg.sv
speed_pkg.sv
playback_ctrl.sv
sample_datapath.sv
speed_player.sv
tb_clock.sv
speed_player_tb.sv

// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = speed_player_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
